// File: Makefile
# Verilator flow for the load/store bus unit testbench

TOP = lsuBusTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/ahbMemModel.sv
/*
  AHB-Lite slave model for the bus unit testbench
  A word memory with pipelined address and data phases. Each accepted
  address phase gets the number of wait states given on waitStates
*/
`timescale 1ns/10ps
`default_nettype none

module ahbMemModel (
  input  wire                      clk,
  input  wire                      reset,
  input  wire busProtoPkg::busReqT busReq,
  input  wire  [1:0]               waitStates,
  output logic                     hready,
  output lsuReqPkg::wordT          hrdata
);

  localparam int memWords = 256;

  lsuReqPkg::wordT mem [memWords];

  // Data phase in flight, taken from the last accepted address phase
  logic       dataActive;
  logic       dataWrite;
  logic [7:0] dataIndex;
  logic [1:0] waitLeft;

  // The slave is ready when idle or once its wait states have run out
  assign hready = ~dataActive | (waitLeft == 2'd0);
  assign hrdata = (dataActive & ~dataWrite) ? mem[dataIndex] : '0;

  always @(posedge clk) begin
    if (reset) begin
      dataActive <= 1'b0;
      dataWrite  <= 1'b0;
      dataIndex  <= '0;
      waitLeft   <= '0;
    end else if (hready) begin
      // Write data belongs to the data phase that completes now
      if (dataActive && dataWrite) begin
        mem[dataIndex] <= busReq.wdata;
      end
      dataActive <= (busReq.trans != busProtoPkg::transIdle);
      dataWrite  <= busReq.write;
      dataIndex  <= busReq.addr[9:2];
      waitLeft   <= waitStates;
    end else begin
      waitLeft <= waitLeft - 2'd1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Backdoor access for the testbench
  ////////////////////////////////////////////////////////////

  task automatic loadWord(input logic [7:0] index, input lsuReqPkg::wordT value);
    mem[index] <= value;
  endtask

  function automatic lsuReqPkg::wordT peekWord(input logic [7:0] index);
    return mem[index];
  endfunction

endmodule

`default_nettype wire

// File: bench/lsuBusTb.sv
/*
  Testbench of the load/store bus unit
  Runs uncached reads and writes, line fetches and writebacks against
  an AHB-Lite memory model with random wait states, and checks them
  against a reference copy of the memory
*/
`timescale 1ns/10ps
`default_nettype none

`include "lsuBusSettings_settings.svh"

module lsuBusTb;

  localparam int memWords  = 256;
  localparam int waitLimit = 100;

  logic                clk;
  logic                reset;
  lsuReqPkg::memReqT   memReq;
  logic                ignoreRequest;
  logic                fetchLine;
  logic                writeLine;
  logic                cpuBusy;
  lsuReqPkg::paddrT    lineBase;
  lsuReqPkg::lineT     wbLine;
  logic                busStall;
  logic                busCommitted;
  logic                lineAck;
  lsuReqPkg::lineT     fillLine;
  lsuReqPkg::wordT     uncachedRdata;
  busProtoPkg::busReqT busReq;
  logic                hready;
  lsuReqPkg::wordT     hrdata;
  logic [1:0]          waitStates;

  // Reference memory and what the bus monitor has seen
  lsuReqPkg::wordT     refMem [memWords];
  busProtoPkg::busReqT addrPhases[$];
  int                  lineAckCount;

  lsuBusTop i_dut (
    .clk           (clk),
    .reset         (reset),
    .memReq        (memReq),
    .ignoreRequest (ignoreRequest),
    .fetchLine     (fetchLine),
    .writeLine     (writeLine),
    .lineBase      (lineBase),
    .wbLine        (wbLine),
    .cpuBusy       (cpuBusy),
    .busStall      (busStall),
    .busCommitted  (busCommitted),
    .lineAck       (lineAck),
    .fillLine      (fillLine),
    .uncachedRdata (uncachedRdata),
    .busReq        (busReq),
    .hready        (hready),
    .hrdata        (hrdata)
  );

  ahbMemModel slave (
    .clk        (clk),
    .reset      (reset),
    .busReq     (busReq),
    .waitStates (waitStates),
    .hready     (hready),
    .hrdata     (hrdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Checks and helpers
  ////////////////////////////////////////////////////////////

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string testName, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (expected === actual) else begin
      $display("FAILED %s: expected %h, actual %h", testName, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // Advance one cycle; inputs change 1 ns after the edge
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    #1;
    r = $urandom;
    waitStates = r[1:0];
  endtask

  task automatic clearMonitor();
    addrPhases.delete();
    lineAckCount = 0;
  endtask

  task automatic waitStallLow(input string testName);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (busStall && n < waitLimit);
    if (busStall) failRun({testName, ": busStall never fell"});
  endtask

  task automatic waitLineAck(input string testName);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (!lineAck && n < waitLimit);
    if (!lineAck) failRun({testName, ": lineAck never pulsed"});
  endtask

  // Compare the recorded address phases with the expected beats
  task automatic checkPhases(input string testName, input lsuReqPkg::paddrT base,
                             input logic isWrite, input int beats,
                             input busProtoPkg::hburstT burst);
    checkValue({testName, " beats"}, beats, addrPhases.size());
    for (int i = 0; i < beats; i++) begin
      checkValue({testName, " addr"}, base + 32'(4 * i), addrPhases[i].addr);
      checkValue({testName, " write"}, 32'(isWrite), 32'(addrPhases[i].write));
      checkValue({testName, " burst"}, 32'(burst), 32'(addrPhases[i].burst));
      checkValue({testName, " trans"},
                 32'((i == 0) ? busProtoPkg::transNonseq : busProtoPkg::transSeq),
                 32'(addrPhases[i].trans));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus monitor, sampled mid-cycle where everything is settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset) begin
      if (busReq.trans != busProtoPkg::transIdle && hready) addrPhases.push_back(busReq);
      if (lineAck) lineAckCount++;
      // A data phase held in wait states must keep the core stalled
      assert (hready || busStall) else failRun("busStall low while the bus is waiting");
    end
  end

  ////////////////////////////////////////////////////////////
  // Transfer tasks
  ////////////////////////////////////////////////////////////

  task automatic uncachedAccess(input logic isWrite, input lsuReqPkg::paddrT addr,
                                input lsuReqPkg::wordT data, input string testName);
    clearMonitor();
    memReq.rwm       = isWrite ? 2'b01 : 2'b10;
    memReq.addr      = addr;
    memReq.wdata     = data;
    memReq.cacheable = 1'b0;
    waitStallLow(testName);
    memReq.rwm = 2'b00;
    checkPhases(testName, addr, isWrite, 1, busProtoPkg::burstSingle);
    if (isWrite) begin
      refMem[addr[9:2]] = data;
      checkValue({testName, " memory"}, data, slave.peekWord(addr[9:2]));
    end else begin
      checkValue({testName, " rdata"}, refMem[addr[9:2]], uncachedRdata);
    end
  endtask

  task automatic lineFetch(input lsuReqPkg::paddrT base);
    logic [7:0] idx;
    idx = base[9:2];
    clearMonitor();
    lineBase  = base;
    fetchLine = 1'b1;
    waitLineAck("line fetch");
    // The whole line is visible in the acknowledging cycle
    for (int i = 0; i < `WORDS_PER_LINE; i++) begin
      checkValue($sformatf("line fetch word %0d", i), refMem[idx + 8'(i)], fillLine[i]);
    end
    fetchLine = 1'b0;
    waitStallLow("line fetch");
    checkPhases("line fetch", base, 1'b0, `WORDS_PER_LINE, busProtoPkg::burstIncr4);
    checkValue("line fetch acks", 1, lineAckCount);
  endtask

  task automatic lineWriteback(input lsuReqPkg::paddrT base);
    logic [7:0]  idx;
    logic [31:0] r;
    idx = base[9:2];
    clearMonitor();
    for (int i = 0; i < `WORDS_PER_LINE; i++) begin
      r = $urandom;
      wbLine[i] = r;
    end
    lineBase  = base;
    writeLine = 1'b1;
    waitLineAck("writeback");
    writeLine = 1'b0;
    waitStallLow("writeback");
    checkPhases("writeback", base, 1'b1, `WORDS_PER_LINE, busProtoPkg::burstIncr4);
    checkValue("writeback acks", 1, lineAckCount);
    for (int i = 0; i < `WORDS_PER_LINE; i++) begin
      refMem[idx + 8'(i)] = wbLine[i];
      checkValue($sformatf("writeback word %0d", i), wbLine[i], slave.peekWord(idx + 8'(i)));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]      r;
    lsuReqPkg::paddrT addr;
    r             = $urandom(62);
    reset         = 1'b1;
    memReq        = '0;
    ignoreRequest = 1'b0;
    fetchLine     = 1'b0;
    writeLine     = 1'b0;
    cpuBusy       = 1'b0;
    lineBase      = '0;
    wbLine        = '0;
    waitStates    = 2'b00;
    lineAckCount  = 0;
    // Same random contents in the model and the reference copy
    for (int i = 0; i < memWords; i++) begin
      r = $urandom;
      refMem[i] = r;
      slave.loadWord(8'(i), r);
    end
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    step();

    checkValue("reset busStall", 0, 32'(busStall));
    checkValue("reset busCommitted", 0, 32'(busCommitted));
    checkValue("reset lineAck", 0, 32'(lineAck));
    checkValue("reset trans", 32'(busProtoPkg::transIdle), 32'(busReq.trans));

    // Uncached writes, each read back, plus reads of other words
    for (int t = 0; t < 8; t++) begin
      r = $urandom;
      addr = {22'b0, r[7:0], 2'b00};
      uncachedAccess(1'b1, addr, $urandom, "uncached write");
      uncachedAccess(1'b0, addr, '0, "uncached readback");
      r = $urandom;
      uncachedAccess(1'b0, {22'b0, r[7:0], 2'b00}, '0, "uncached read");
    end

    // Writeback of a line then a fetch of it and of another line
    for (int t = 0; t < 6; t++) begin
      r = $urandom;
      addr = {22'b0, r[7:2], 4'b0000};
      lineWriteback(addr);
      lineFetch(addr);
      r = $urandom;
      lineFetch({22'b0, r[7:2], 4'b0000});
    end

    // Ignored requests start nothing on the bus
    clearMonitor();
    ignoreRequest    = 1'b1;
    memReq.rwm       = 2'b10;
    memReq.cacheable = 1'b0;
    fetchLine        = 1'b1;
    for (int t = 0; t < 6; t++) begin
      step();
      checkValue("ignore busStall", 0, 32'(busStall));
      checkValue("ignore busCommitted", 0, 32'(busCommitted));
    end
    ignoreRequest = 1'b0;
    memReq.rwm    = 2'b00;
    fetchLine     = 1'b0;
    step();
    checkValue("ignore beats", 0, addrPhases.size());

    // A busy core keeps the unit committed after an uncached access
    cpuBusy = 1'b1;
    r = $urandom;
    uncachedAccess(1'b0, {22'b0, r[7:0], 2'b00}, '0, "busy read");
    for (int t = 0; t < 5; t++) begin
      checkValue("busy busCommitted", 1, 32'(busCommitted));
      step();
    end
    cpuBusy = 1'b0;
    step();
    checkValue("busy release", 0, 32'(busCommitted));

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
design/lsuReqPkg.sv
design/busProtoPkg.sv
design/busFsm.sv
design/beatAddrGen.sv
design/lineXferBuffer.sv
design/lsuBusTop.sv
bench/ahbMemModel.sv
bench/lsuBusTb.sv

// File: design/beatAddrGen.sv
/*
  Beat address generator
  Forms the bus address of each beat from either the uncached request
  address or the line base and current word count, and packs the bus
  request with its transfer control and write data
*/
`timescale 1ns/10ps
`default_nettype none

`include "lsuBusSettings_settings.svh"

module beatAddrGen (
  input  wire lsuReqPkg::memReqT    memReq,
  input  wire lsuReqPkg::paddrT     lineBase,
  input  wire lsuReqPkg::wordCountT wordCount,
  input  wire                       selUncachedAdr,
  input  wire                       busRead,
  input  wire                       busWrite,
  input  wire busProtoPkg::htransT  transType,
  input  wire busProtoPkg::hburstT  burstType,
  input  wire lsuReqPkg::wordT      wbWord,
  output busProtoPkg::busReqT       busReq
);

  // Byte offset bits below the word index
  localparam int byteBits = $clog2(`XLEN / 8);

  lsuReqPkg::paddrT lineAddr;

  // Line base keeps its upper bits; the word count fills the word offset
  assign lineAddr = {lineBase[`PA_BITS-1:`LOG_WPL+byteBits], wordCount, {byteBits{1'b0}}};

  always_comb begin
    busReq.addr  = selUncachedAdr ? memReq.addr : lineAddr;
    busReq.write = busWrite;
    // No transfer goes out unless a read or a write is asked for
    busReq.trans = (busRead | busWrite) ? transType : busProtoPkg::transIdle;
    busReq.burst = burstType;
    // Uncached stores carry the request word, writebacks the buffered line word
    busReq.wdata = selUncachedAdr ? memReq.wdata : wbWord;
  end

endmodule

`default_nettype wire

// File: design/busFsm.sv
/*
  Bus sequencer of the load/store unit
  Runs uncached single-word accesses and cache line fetches and writebacks
  as pipelined AHB-Lite transfers. Keeps an address-phase word counter and
  a data-phase counter one beat behind it, and drives the stall, commit
  and transfer control outputs
*/
`timescale 1ns/10ps
`default_nettype none

`include "lsuBusSettings_settings.svh"

module busFsm (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     ignoreRequest,
  input  wire  [1:0]              rwm,
  input  wire                     fetchLine,
  input  wire                     writeLine,
  input  wire                     busAck,
  input  wire                     cpuBusy,
  input  wire                     cacheable,
  output logic                    busStall,
  output logic                    busWrite,
  output logic                    busRead,
  output busProtoPkg::hburstT     burstType,
  output busProtoPkg::htransT     transType,
  output logic                    transComplete,
  output logic                    lineAck,
  output logic                    busCommitted,
  output logic                    selUncachedAdr,
  output lsuReqPkg::wordCountT    wordCount,
  output lsuReqPkg::wordCountT    wordCountDelayed
);

  // Index of the final word in a line
  localparam lsuReqPkg::wordCountT lastWord = lsuReqPkg::wordCountT'(`WORDS_PER_LINE - 1);

  lsuReqPkg::busStateT currState;
  lsuReqPkg::busStateT nextState;

  logic                uncachedAccess;
  logic                requestLive;
  logic                uncWriteStart;
  logic                uncReadStart;
  logic                fetchStart;
  logic                wbStart;
  logic                lineActive;
  logic                uncachedRw;
  logic                wordCountFlag;
  logic                addrActive;
  logic                cntEn;
  logic                cntReset;
  busProtoPkg::hburstT lineBurst;

  ////////////////////////////////////////////////////////////
  // Request decode
  ////////////////////////////////////////////////////////////

  // Without a cache every access goes straight to the bus
  assign uncachedAccess = (`CACHE_ENABLED == 0) | ~cacheable;
  assign requestLive    = (currState == lsuReqPkg::stateReady) & ~ignoreRequest;

  // Start conditions seen in the ready state, in priority order
  assign uncWriteStart = requestLive & uncachedAccess & rwm[0];
  assign uncReadStart  = requestLive & uncachedAccess & rwm[1] & ~rwm[0];
  assign fetchStart    = requestLive & ~(uncachedAccess & (|rwm)) & fetchLine;
  assign wbStart       = requestLive & ~(uncachedAccess & (|rwm)) & ~fetchLine & writeLine;

  assign lineActive = (currState == lsuReqPkg::stateFetch) |
                      (currState == lsuReqPkg::stateWrite);

  // An uncached beat is either starting now or waiting on its data phase
  assign uncachedRw = uncWriteStart | uncReadStart |
                      (currState == lsuReqPkg::stateUncachedWrite) |
                      (currState == lsuReqPkg::stateUncachedRead);

  ////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      currState <= lsuReqPkg::stateReady;
    end else begin
      currState <= nextState;
    end
  end

  always_comb begin
    nextState = currState;
    case (currState)
      lsuReqPkg::stateReady: begin
        if (uncWriteStart) nextState = lsuReqPkg::stateUncachedWrite;
        else if (uncReadStart) nextState = lsuReqPkg::stateUncachedRead;
        else if (fetchStart) nextState = lsuReqPkg::stateFetch;
        else if (wbStart) nextState = lsuReqPkg::stateWrite;
      end
      lsuReqPkg::stateUncachedWrite: begin
        if (busAck) nextState = lsuReqPkg::stateUncachedWriteDone;
      end
      lsuReqPkg::stateUncachedRead: begin
        if (busAck) nextState = lsuReqPkg::stateUncachedReadDone;
      end
      // Both done states hold off the next access while the core is busy
      lsuReqPkg::stateUncachedWriteDone,
      lsuReqPkg::stateUncachedReadDone,
      lsuReqPkg::stateCpuBusy: begin
        nextState = cpuBusy ? lsuReqPkg::stateCpuBusy : lsuReqPkg::stateReady;
      end
      lsuReqPkg::stateFetch,
      lsuReqPkg::stateWrite: begin
        if (wordCountFlag & busAck) nextState = lsuReqPkg::stateReady;
      end
      default: nextState = lsuReqPkg::stateReady;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Word counters
  ////////////////////////////////////////////////////////////

  // The delayed counter names the beat in its data phase; the line is done
  // once it points at the last word
  assign wordCountFlag = (wordCountDelayed == lastWord);

  // Count each accepted address phase of a line, from the ready cycle on
  assign cntEn    = (fetchStart | wbStart | lineActive) & busAck & ~wordCountFlag;
  assign cntReset = ((currState == lsuReqPkg::stateReady) & ~(fetchStart | wbStart)) |
                    transComplete;

  always_ff @(posedge clk) begin
    if (reset || cntReset) begin
      wordCount        <= '0;
      wordCountDelayed <= '0;
    end else if (cntEn) begin
      wordCount        <= wordCount + lsuReqPkg::wordCountT'(1);
      wordCountDelayed <= wordCount;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bus control outputs
  ////////////////////////////////////////////////////////////

  // Burst length follows the line size; 16 words is the longest fixed burst
  always_comb begin
    case (`WORDS_PER_LINE)
      4:       lineBurst = busProtoPkg::burstIncr4;
      8:       lineBurst = busProtoPkg::burstIncr8;
      16:      lineBurst = busProtoPkg::burstIncr16;
      default: lineBurst = busProtoPkg::burstIncr;
    endcase
  end

  assign burstType = uncachedRw ? busProtoPkg::burstSingle : lineBurst;

  // Address phases run until the last line address has been sent
  assign addrActive = uncWriteStart | uncReadStart | fetchStart | wbStart |
                      (lineActive & ~wordCountFlag);

  // First beat is NONSEQ, later line beats SEQ, IDLE once addresses are done
  assign transType = ~addrActive                   ? busProtoPkg::transIdle :
                     ((|wordCount) & ~uncachedRw)  ? busProtoPkg::transSeq  :
                                                     busProtoPkg::transNonseq;

  assign transComplete = (((currState == lsuReqPkg::stateUncachedWrite) |
                           (currState == lsuReqPkg::stateUncachedRead)) |
                          (lineActive & wordCountFlag)) & busAck;

  assign lineAck = lineActive & wordCountFlag & busAck;

  assign busWrite = uncWriteStart | wbStart |
                    (currState == lsuReqPkg::stateUncachedWrite) |
                    (currState == lsuReqPkg::stateWrite);
  assign busRead  = uncReadStart | fetchStart |
                    (currState == lsuReqPkg::stateUncachedRead) |
                    (currState == lsuReqPkg::stateFetch);

  // The core stalls from the cycle a request is seen until its data returns
  assign busStall = uncWriteStart | uncReadStart | fetchStart | wbStart | lineActive |
                    (currState == lsuReqPkg::stateUncachedWrite) |
                    (currState == lsuReqPkg::stateUncachedRead);

  assign busCommitted = (currState != lsuReqPkg::stateReady);

  // Uncached states take the request address; a cacheless build always does
  assign selUncachedAdr = ((currState == lsuReqPkg::stateReady) & (|rwm) & uncachedAccess) |
                          (currState == lsuReqPkg::stateUncachedWrite) |
                          (currState == lsuReqPkg::stateUncachedWriteDone) |
                          (currState == lsuReqPkg::stateUncachedRead) |
                          (currState == lsuReqPkg::stateUncachedReadDone) |
                          (`CACHE_ENABLED == 0);

endmodule

`default_nettype wire

// File: design/busProtoPkg.sv
/*
  Bus-side types of the load/store bus unit
  AHB-Lite transfer and burst encodings and the request bundle that the
  unit drives onto the bus. Address and data fields use the core-side
  word types of lsuReqPkg, which is compiled first
*/
`default_nettype none

package busProtoPkg;

  // HTRANS encoding; BUSY is never issued by this unit
  typedef enum logic [1:0] {
    transIdle   = 2'b00,
    transNonseq = 2'b10,
    transSeq    = 2'b11
  } htransT;

  // HBURST encoding, incrementing bursts only
  typedef enum logic [2:0] {
    burstSingle = 3'b000,
    burstIncr   = 3'b001,
    burstIncr4  = 3'b011,
    burstIncr8  = 3'b101,
    burstIncr16 = 3'b111
  } hburstT;

  // Address-phase control together with the data-phase write word.
  // Size is always a full word so it is not carried here
  typedef struct packed {
    lsuReqPkg::paddrT addr;
    logic             write;
    htransT           trans;
    hburstT           burst;
    lsuReqPkg::wordT  wdata;
  } busReqT;

endpackage

`default_nettype wire

// File: design/lineXferBuffer.sv
/*
  Line transfer buffer
  Collects fetched words into a line, presents writeback words in step
  with the bus data phase and holds the last uncached read word
*/
`timescale 1ns/10ps
`default_nettype none

`include "lsuBusSettings_settings.svh"

module lineXferBuffer (
  input  wire                       clk,
  input  wire                       reset,
  input  wire                       hready,
  input  wire lsuReqPkg::wordT      hrdata,
  input  wire                       fillActive,
  input  wire                       uncachedRead,
  input  wire lsuReqPkg::wordCountT wordCountDelayed,
  input  wire lsuReqPkg::wordCountT wordCount,
  input  wire lsuReqPkg::lineT      wbLine,
  output lsuReqPkg::lineT           fillLine,
  output lsuReqPkg::wordT           wbWord,
  output lsuReqPkg::wordT           uncachedRdata
);

  lsuReqPkg::lineT fillRegs;
  logic            fillWrite;

  ////////////////////////////////////////////////////////////
  // Line fill
  ////////////////////////////////////////////////////////////

  // A fetch beat lands when its data phase is acknowledged
  assign fillWrite = fillActive & hready;

  // Each word goes to the slot named by the data-phase counter
  always_ff @(posedge clk) begin
    if (fillWrite) begin
      fillRegs[wordCountDelayed] <= hrdata;
    end
  end

  // The word arriving in this cycle is passed through as well, so the
  // whole line is present in the cycle that acknowledges the last beat
  always_comb begin
    fillLine = fillRegs;
    if (fillWrite) begin
      fillLine[wordCountDelayed] = hrdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Writeback word
  ////////////////////////////////////////////////////////////

  // Write data trails its address by one beat. The word for the address
  // just accepted is loaded here, so during each data phase this holds
  // the word at the delayed count. With hready low the word stays put
  always_ff @(posedge clk) begin
    if (hready) begin
      wbWord <= wbLine[wordCount];
    end
  end

  ////////////////////////////////////////////////////////////
  // Uncached read data
  ////////////////////////////////////////////////////////////

  // Taken on the acknowledging cycle, valid from the done state onward
  always_ff @(posedge clk) begin
    if (reset) begin
      uncachedRdata <= '0;
    end else if (uncachedRead && hready) begin
      uncachedRdata <= hrdata;
    end
  end

endmodule

`default_nettype wire

// File: design/lsuBusTop.sv
/*
  Data-side bus unit of the load/store unit
  Joins the bus sequencer, the beat address generator and the line
  transfer buffer between the core and cache side and the AHB-Lite bus
*/
`timescale 1ns/10ps
`default_nettype none

module lsuBusTop (
  input  wire                      clk,
  input  wire                      reset,
  // Core and cache side
  input  wire lsuReqPkg::memReqT   memReq,
  input  wire                      ignoreRequest,
  input  wire                      fetchLine,
  input  wire                      writeLine,
  input  wire lsuReqPkg::paddrT    lineBase,
  input  wire lsuReqPkg::lineT     wbLine,
  input  wire                      cpuBusy,
  output logic                     busStall,
  output logic                     busCommitted,
  output logic                     lineAck,
  output lsuReqPkg::lineT          fillLine,
  output lsuReqPkg::wordT          uncachedRdata,
  // Bus side
  output busProtoPkg::busReqT      busReq,
  input  wire                      hready,
  input  wire lsuReqPkg::wordT     hrdata
);

  lsuReqPkg::wordCountT wordCount;
  lsuReqPkg::wordCountT wordCountDelayed;
  logic                 selUncachedAdr;
  logic                 busRead;
  logic                 busWrite;
  logic                 transComplete;
  busProtoPkg::htransT  transType;
  busProtoPkg::hburstT  burstType;
  lsuReqPkg::wordT      wbWord;
  logic                 fillActive;
  logic                 uncachedRead;

  // Fetch state is a committed cached read
  assign fillActive   = busRead & ~selUncachedAdr & busCommitted;
  // Uncached read data returns on the completing acknowledge
  assign uncachedRead = busRead & selUncachedAdr & transComplete;

  busFsm i_busFsm (
    .clk              (clk),
    .reset            (reset),
    .ignoreRequest    (ignoreRequest),
    .rwm              (memReq.rwm),
    .fetchLine        (fetchLine),
    .writeLine        (writeLine),
    .busAck           (hready),
    .cpuBusy          (cpuBusy),
    .cacheable        (memReq.cacheable),
    .busStall         (busStall),
    .busWrite         (busWrite),
    .busRead          (busRead),
    .burstType        (burstType),
    .transType        (transType),
    .transComplete    (transComplete),
    .lineAck          (lineAck),
    .busCommitted     (busCommitted),
    .selUncachedAdr   (selUncachedAdr),
    .wordCount        (wordCount),
    .wordCountDelayed (wordCountDelayed)
  );

  beatAddrGen i_beatAddrGen (
    .memReq         (memReq),
    .lineBase       (lineBase),
    .wordCount      (wordCount),
    .selUncachedAdr (selUncachedAdr),
    .busRead        (busRead),
    .busWrite       (busWrite),
    .transType      (transType),
    .burstType      (burstType),
    .wbWord         (wbWord),
    .busReq         (busReq)
  );

  lineXferBuffer i_lineXferBuffer (
    .clk              (clk),
    .reset            (reset),
    .hready           (hready),
    .hrdata           (hrdata),
    .fillActive       (fillActive),
    .uncachedRead     (uncachedRead),
    .wordCountDelayed (wordCountDelayed),
    .wordCount        (wordCount),
    .wbLine           (wbLine),
    .fillLine         (fillLine),
    .wbWord           (wbWord),
    .uncachedRdata    (uncachedRdata)
  );

endmodule

`default_nettype wire

// File: design/lsuReqPkg.sv
/*
  Core-side types of the load/store bus unit
  Data words, physical addresses, line word indices, the bus sequencer
  states and the memory-stage request bundle
*/
`default_nettype none

`include "lsuBusSettings_settings.svh"

package lsuReqPkg;

  // One bus data word
  typedef logic [`XLEN-1:0] wordT;

  // Physical address as seen on the bus
  typedef logic [`PA_BITS-1:0] paddrT;

  // Index of a word inside a cache line
  typedef logic [`LOG_WPL-1:0] wordCountT;

  // A whole cache line, word 0 in the lowest slot
  typedef wordT [`WORDS_PER_LINE-1:0] lineT;

  // States of the bus sequencer
  typedef enum logic [2:0] {
    stateReady,
    stateFetch,
    stateWrite,
    stateUncachedWrite,
    stateUncachedWriteDone,
    stateUncachedRead,
    stateUncachedReadDone,
    stateCpuBusy
  } busStateT;

  // Memory-stage request; rwm bit 1 asks for a read and bit 0 for a write
  typedef struct packed {
    logic [1:0] rwm;
    paddrT      addr;
    wordT       wdata;
    logic       cacheable;
  } memReqT;

endpackage

`default_nettype wire

// File: include/lsuBusSettings_settings.svh
/*
  Build settings for the data-side bus unit of the load/store unit.
  Word and address widths, the cache line length and the cache option
*/
`ifndef LSU_BUS_SETTINGS_SVH
`define LSU_BUS_SETTINGS_SVH

// Width of one bus data word in bits
`define XLEN 32

// Width of a physical address in bits
`define PA_BITS 32

// Words in one cache line, which may be 4, 8 or 16
`define WORDS_PER_LINE 4

// Width of the word counter, tracking the line length
`define LOG_WPL $clog2(`WORDS_PER_LINE)

// Set to 0 for a build without a data cache, so every access goes uncached
`define CACHE_ENABLED 1

`endif
